// File: hdl/decode_if.sv
// decoded instruction fields
interface decode_if import idu_pkg::*; #(
    parameter int xlen = 64
) ();

    op_e             op;
    reg_idx_t        rd;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    logic [xlen-1:0] imm_i;    // all immediates sign-extended
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [5:0]      shamt;

    modport decoder (output op, rd, rs1, rs2, imm_i, imm_s, imm_u, imm_j, shamt);

    modport hazard (input op, rs1, rs2);

    modport operands (input op, rs1, rs2, imm_i, imm_s, imm_u, imm_j, shamt);

endinterface

// File: hdl/hazard_check.sv
// source register busy check
module hazard_check import idu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    decode_if.hazard    dec,
    input  logic [31:0] gpr_busy,
    output logic        stall
);

    logic need_rs1;
    logic need_rs2;

    // rs1 is an operand for everything except the pc and upper-immediate forms
    assign need_rs1 = !(dec.op inside {op_none, op_lui, op_auipc, op_jal});

    // stores need rs2 for their data even though the ALU ignores it
    assign need_rs2 = dec.op inside {
        op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_or, op_and,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_sb, op_sh, op_sw, op_sd
    };

    assign stall = (need_rs1 && gpr_busy[dec.rs1]) ||
                   (need_rs2 && gpr_busy[dec.rs2]);

    // an empty or unknown slot must never block fetch
    a_no_stall_none: assert property (@(posedge clk) disable iff (rst)
        (dec.op == op_none) |-> !stall)
        else $error("stall raised for op_none");

endmodule

// File: hdl/id_latch.sv
// decode stage input register
module id_latch import idu_pkg::*; #(
    parameter int xlen = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_if_id,
    input  logic [xlen-1:0] pc_if_id,
    input  logic [31:0]     inst_if_id,
    input  logic            stall,
    output logic            held_valid,
    output logic [xlen-1:0] held_pc,
    output logic [31:0]     held_inst,
    output logic            ready_if_id,
    output logic            valid_id_ex,
    output logic [xlen-1:0] pc_id_ex,
    output logic [31:0]     inst_id_ex
);

    logic [31:0] inst_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (!stall) begin
            held_valid <= valid_if_id;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            held_pc <= pc_if_id;
            inst_q  <= inst_if_id;
        end
    end

    assign held_inst   = held_valid ? inst_q : 32'b0;    // empty stage decodes as op_none
    assign ready_if_id = !stall;
    assign valid_id_ex = held_valid && !stall;
    assign pc_id_ex    = stall ? '0 : held_pc;
    assign inst_id_ex  = stall ? 32'b0 : inst_q;

    // the scoreboard stall must freeze the register across the edge
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(held_pc))
        else $error("held_pc changed while stalled");

endmodule

// File: hdl/idu_pkg.sv
// decode stage shared types
package idu_pkg;

    typedef logic [4:0] reg_idx_t;

    // major opcode field, inst[6:0]
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_reg    = 7'b0110011;

    // decoded instruction, op_none for anything not supported
    typedef enum logic [5:0] {
        op_none,
        op_lui, op_auipc, op_jal, op_jalr,
        // branches
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        // loads
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        // stores
        op_sb, op_sh, op_sw, op_sd,
        // register-immediate
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        // register-register
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_or, op_and
    } op_e;

    // execute stage ALU function select
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10    // only srai uses this
    } alu_mode_e;

endpackage

// File: hdl/idu_top.sv
// instruction decode stage
module idu_top import idu_pkg::*; #(
    parameter int xlen = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_if_id,
    input  logic [xlen-1:0] pc_if_id,
    input  logic [31:0]     inst_if_id,
    input  logic [xlen-1:0] gpr [32],
    input  logic [31:0]     gpr_busy,
    output logic            ready_if_id,
    output logic            valid_id_ex,
    output logic [xlen-1:0] pc_id_ex,
    output logic [31:0]     inst_id_ex,
    output logic [xlen-1:0] alu_a,
    output logic [xlen-1:0] alu_b,
    output alu_mode_e       alu_mode,
    output logic [xlen-1:0] src2,
    output reg_idx_t        rd,
    output logic            wen,
    output op_e             opcode
);

    logic            stall;
    logic [xlen-1:0] held_pc;
    logic [31:0]     held_inst;

    decode_if #(.xlen(xlen)) dec_if ();

    id_latch #(.xlen(xlen)) u_latch (
        .clk         (clk),
        .rst         (rst),
        .valid_if_id (valid_if_id),
        .pc_if_id    (pc_if_id),
        .inst_if_id  (inst_if_id),
        .stall       (stall),
        .held_valid  (),              // already folded into held_inst
        .held_pc     (held_pc),
        .held_inst   (held_inst),
        .ready_if_id (ready_if_id),
        .valid_id_ex (valid_id_ex),
        .pc_id_ex    (pc_id_ex),
        .inst_id_ex  (inst_id_ex)
    );

    inst_decoder #(.xlen(xlen)) u_decoder (
        .held_inst (held_inst),
        .dec       (dec_if.decoder),
        .wen       (wen)
    );

    hazard_check u_hazard (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec_if.hazard),
        .gpr_busy (gpr_busy),
        .stall    (stall)
    );

    operand_select #(.xlen(xlen)) u_operands (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec_if.operands),
        .gpr      (gpr),
        .held_pc  (held_pc),
        .alu_a    (alu_a),
        .alu_b    (alu_b),
        .alu_mode (alu_mode),
        .src2     (src2)
    );

    assign rd     = dec_if.rd;
    assign opcode = dec_if.op;

endmodule

// File: hdl/inst_decoder.sv
// instruction classify and field extract
module inst_decoder import idu_pkg::*; #(
    parameter int xlen = 64
) (
    input  logic [31:0] held_inst,
    decode_if.decoder   dec,
    output logic        wen
);

    localparam int sh_w = $clog2(xlen);
    // funct bits above the shift amount, 010000 on rv64
    localparam logic [11-sh_w:0] hi_srai = {2'b01, {(10 - sh_w){1'b0}}};

    op_e               op;
    logic [6:0]        opc;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic [11-sh_w:0]  shift_hi;

    assign opc      = held_inst[6:0];
    assign f3       = held_inst[14:12];
    assign f7       = held_inst[31:25];
    assign shift_hi = held_inst[31:20+sh_w];

    always_comb begin
        op = op_none;
        case (opc)
            opc_lui:    op = op_lui;
            opc_auipc:  op = op_auipc;
            opc_jal:    op = op_jal;
            opc_jalr:   if (f3 == 3'b000) op = op_jalr;
            opc_branch: case (f3)
                3'b000:  op = op_beq;
                3'b001:  op = op_bne;
                3'b100:  op = op_blt;
                3'b101:  op = op_bge;
                3'b110:  op = op_bltu;
                3'b111:  op = op_bgeu;
                default: op = op_none;
            endcase
            opc_load: case (f3)
                3'b000:  op = op_lb;
                3'b001:  op = op_lh;
                3'b010:  op = op_lw;
                3'b011:  op = op_ld;
                3'b100:  op = op_lbu;
                3'b101:  op = op_lhu;
                3'b110:  op = op_lwu;
                default: op = op_none;
            endcase
            opc_store: case (f3)
                3'b000:  op = op_sb;
                3'b001:  op = op_sh;
                3'b010:  op = op_sw;
                3'b011:  op = op_sd;
                default: op = op_none;
            endcase
            opc_imm: case (f3)
                3'b000: op = op_addi;
                3'b010: op = op_slti;
                3'b011: op = op_sltiu;
                3'b100: op = op_xori;
                3'b110: op = op_ori;
                3'b111: op = op_andi;
                3'b001: if (shift_hi == '0) op = op_slli;
                default: begin    // f3 101, logical or arithmetic right
                    if (shift_hi == '0) op = op_srli;
                    else if (shift_hi == hi_srai) op = op_srai;
                end
            endcase
            opc_reg: case ({f7, f3})
                10'b0000000_000: op = op_add;
                10'b0100000_000: op = op_sub;
                10'b0000000_001: op = op_sll;
                10'b0000000_010: op = op_slt;
                10'b0000000_011: op = op_sltu;
                10'b0000000_100: op = op_xor;
                10'b0000000_101: op = op_srl;
                10'b0000000_110: op = op_or;
                10'b0000000_111: op = op_and;
                default:         op = op_none;
            endcase
            default: op = op_none;
        endcase
    end

    assign dec.op    = op;
    assign dec.rd    = held_inst[11:7];
    assign dec.rs1   = held_inst[19:15];
    assign dec.rs2   = held_inst[24:20];
    assign dec.shamt = 6'(held_inst[20 +: sh_w]);

    assign dec.imm_i = xlen'($signed(held_inst[31:20]));
    assign dec.imm_s = xlen'($signed({held_inst[31:25], held_inst[11:7]}));
    assign dec.imm_u = xlen'($signed({held_inst[31:12], 12'b0}));
    assign dec.imm_j = xlen'($signed({held_inst[31], held_inst[19:12], held_inst[20],
                                      held_inst[30:21], 1'b0}));

    // no register result for branches, stores or unknown encodings
    assign wen = !(op inside {op_none, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
                              op_sb, op_sh, op_sw, op_sd});

endmodule

// File: hdl/operand_select.sv
// ALU operand and mode select
module operand_select import idu_pkg::*; #(
    parameter int xlen = 64
) (
    input  logic            clk,
    input  logic            rst,
    decode_if.operands      dec,
    input  logic [xlen-1:0] gpr [32],
    input  logic [xlen-1:0] held_pc,
    output logic [xlen-1:0] alu_a,
    output logic [xlen-1:0] alu_b,
    output alu_mode_e       alu_mode,
    output logic [xlen-1:0] src2
);

    localparam int sh_w = $clog2(xlen);

    logic [xlen-1:0] src1;

    assign src1 = gpr[dec.rs1];
    assign src2 = gpr[dec.rs2];    // also the store data

    always_comb begin
        alu_a = '0;
        alu_b = '0;
        case (dec.op)
            op_add, op_sub, op_slt, op_sltu, op_xor, op_or, op_and,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                alu_a = src1;
                alu_b = src2;
            end
            op_sll, op_srl: begin
                alu_a = src1;
                alu_b = xlen'(src2[sh_w-1:0]);    // shift count only
            end
            op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
            op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu, op_jalr: begin
                alu_a = src1;
                alu_b = dec.imm_i;
            end
            op_sb, op_sh, op_sw, op_sd: begin
                alu_a = src1;
                alu_b = dec.imm_s;
            end
            op_slli, op_srli, op_srai: begin
                alu_a = src1;
                alu_b = xlen'(dec.shamt);
            end
            op_lui: alu_a = dec.imm_u;
            op_auipc: begin
                alu_a = held_pc;
                alu_b = dec.imm_u;
            end
            op_jal: begin
                alu_a = held_pc;
                alu_b = dec.imm_j;
            end
            default: ;    // op_none keeps zero operands
        endcase
    end

    always_comb begin
        case (dec.op)
            op_sub, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: alu_mode = alu_sub;
            op_slt, op_slti:   alu_mode = alu_slt;
            op_sltu, op_sltiu: alu_mode = alu_sltu;
            op_and, op_andi:   alu_mode = alu_and;
            op_or, op_ori:     alu_mode = alu_or;
            op_xor, op_xori:   alu_mode = alu_xor;
            op_sll, op_slli:   alu_mode = alu_sll;
            op_srl, op_srli:   alu_mode = alu_srl;
            op_srai:           alu_mode = alu_sra;
            default:           alu_mode = alu_add;    // address and pc arithmetic
        endcase
    end

    a_mode_legal: assert property (@(posedge clk) disable iff (rst)
        alu_mode inside {alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
                         alu_or, alu_xor, alu_sll, alu_srl, alu_sra})
        else $error("undefined alu_mode %0h", alu_mode);

endmodule

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_top -f src.f -o sim_idu
./obj_dir/sim_idu | tee sim.log
grep -q "^=== PASS ===$" sim.log
echo "simulation passed"

// File: src.f
hdl/idu_pkg.sv
hdl/decode_if.sv
hdl/id_latch.sv
hdl/inst_decoder.sv
hdl/hazard_check.sv
hdl/operand_select.sv
hdl/idu_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: tests/tb_checker.sv
// reference model and output compare
module tb_checker import idu_pkg::*; #(
    parameter int xlen = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_if_id,
    input  logic [xlen-1:0] pc_if_id,
    input  logic [31:0]     inst_if_id,
    input  logic [xlen-1:0] gpr [32],
    input  logic [31:0]     gpr_busy,
    input  logic            ready_if_id,
    input  logic            valid_id_ex,
    input  logic [xlen-1:0] pc_id_ex,
    input  logic [31:0]     inst_id_ex,
    input  logic [xlen-1:0] alu_a,
    input  logic [xlen-1:0] alu_b,
    input  alu_mode_e       alu_mode,
    input  logic [xlen-1:0] src2,
    input  reg_idx_t        rd,
    input  logic            wen,
    input  op_e             opcode,
    output int              errors,
    output int              checks
);

    timeunit 1ns;
    timeprecision 100ps;

    logic            m_valid = 1'b0;    // model of the stage register
    logic [xlen-1:0] m_pc = '0;
    logic [31:0]     m_inst = '0;
    int              n_err = 0;
    int              n_chk = 0;

    assign errors = n_err;
    assign checks = n_chk;

    function automatic op_e ref_decode(input logic [31:0] i);
        op_e        r;
        logic [2:0] f3;
        logic [6:0] f7;

        r  = op_none;
        f3 = i[14:12];
        f7 = i[31:25];
        case (i[6:0])
            7'h37: r = op_lui;
            7'h17: r = op_auipc;
            7'h6f: r = op_jal;
            7'h67: r = (f3 == 3'd0) ? op_jalr : op_none;
            7'h63: begin
                if (f3 == 3'd0) r = op_beq;
                else if (f3 == 3'd1) r = op_bne;
                else if (f3 == 3'd4) r = op_blt;
                else if (f3 == 3'd5) r = op_bge;
                else if (f3 == 3'd6) r = op_bltu;
                else if (f3 == 3'd7) r = op_bgeu;
            end
            7'h03: begin
                if (f3 == 3'd0) r = op_lb;
                else if (f3 == 3'd1) r = op_lh;
                else if (f3 == 3'd2) r = op_lw;
                else if (f3 == 3'd3) r = op_ld;
                else if (f3 == 3'd4) r = op_lbu;
                else if (f3 == 3'd5) r = op_lhu;
                else if (f3 == 3'd6) r = op_lwu;
            end
            7'h23: begin
                if (f3 == 3'd0) r = op_sb;
                else if (f3 == 3'd1) r = op_sh;
                else if (f3 == 3'd2) r = op_sw;
                else r = (f3 == 3'd3) ? op_sd : op_none;
            end
            7'h13: begin
                if (f3 == 3'd0) r = op_addi;
                else if (f3 == 3'd2) r = op_slti;
                else if (f3 == 3'd3) r = op_sltiu;
                else if (f3 == 3'd4) r = op_xori;
                else if (f3 == 3'd6) r = op_ori;
                else if (f3 == 3'd7) r = op_andi;
                else if (f3 == 3'd1 && i[31:26] == 6'h00) r = op_slli;
                else if (f3 == 3'd5 && i[31:26] == 6'h00) r = op_srli;
                else if (f3 == 3'd5 && i[31:26] == 6'h10) r = op_srai;
            end
            7'h33: begin
                if (f7 == 7'h20 && f3 == 3'd0) r = op_sub;
                else if (f7 == 7'h00) begin
                    if (f3 == 3'd0) r = op_add;
                    else if (f3 == 3'd1) r = op_sll;
                    else if (f3 == 3'd2) r = op_slt;
                    else if (f3 == 3'd3) r = op_sltu;
                    else if (f3 == 3'd4) r = op_xor;
                    else if (f3 == 3'd5) r = op_srl;
                    else if (f3 == 3'd6) r = op_or;
                    else r = op_and;
                end
            end
            default: r = op_none;
        endcase
        return r;
    endfunction

    // funct3 gives the ALU function, alt picks sub or sra
    function automatic alu_mode_e f3_mode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? alu_sub : alu_add;
            3'd1:    return alu_sll;
            3'd2:    return alu_slt;
            3'd3:    return alu_sltu;
            3'd4:    return alu_xor;
            3'd5:    return alt ? alu_sra : alu_srl;
            3'd6:    return alu_or;
            default: return alu_and;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic step_model();
        logic [31:0]     held;
        logic [2:0]      f3;
        op_e             op;
        logic [xlen-1:0] s1;
        logic [xlen-1:0] s2;
        logic [xlen-1:0] imm_i;
        logic [xlen-1:0] imm_s;
        logic [xlen-1:0] imm_u;
        logic [xlen-1:0] imm_j;
        logic [xlen-1:0] exp_a;
        logic [xlen-1:0] exp_b;
        alu_mode_e       exp_mode;
        logic            use1;
        logic            use2;
        logic            exp_wen;
        logic            stall;

        held  = m_valid ? m_inst : 32'b0;    // empty stage looks like all zero
        f3    = held[14:12];
        op    = ref_decode(held);
        s1    = gpr[held[19:15]];
        s2    = gpr[held[24:20]];
        imm_i = {{(xlen-12){held[31]}}, held[31:20]};
        imm_s = {{(xlen-12){held[31]}}, held[31:25], held[11:7]};
        imm_u = {{(xlen-32){held[31]}}, held[31:12], 12'b0};
        imm_j = {{(xlen-20){held[31]}}, held[19:12], held[20], held[30:21], 1'b0};

        exp_a    = '0;
        exp_b    = '0;
        exp_mode = alu_add;
        use1     = 1'b0;
        use2     = 1'b0;
        exp_wen  = 1'b0;
        if (op != op_none) begin
            exp_wen = 1'b1;
            use1    = 1'b1;
            exp_a   = s1;
            case (held[6:0])
                7'h33: begin
                    use2     = 1'b1;
                    exp_b    = (f3 == 3'd1 || f3 == 3'd5) ? xlen'(s2[5:0]) : s2;
                    exp_mode = f3_mode(f3, held[30]);
                end
                7'h63: begin
                    use2     = 1'b1;
                    exp_wen  = 1'b0;
                    exp_b    = s2;
                    exp_mode = alu_sub;
                end
                7'h13: begin
                    exp_b    = (f3 == 3'd1 || f3 == 3'd5) ? xlen'(held[25:20]) : imm_i;
                    exp_mode = f3_mode(f3, f3 == 3'd5 && held[30]);
                end
                7'h23: begin
                    use2    = 1'b1;
                    exp_wen = 1'b0;
                    exp_b   = imm_s;
                end
                7'h37: begin
                    use1  = 1'b0;
                    exp_a = imm_u;
                end
                7'h17: begin
                    use1  = 1'b0;
                    exp_a = m_pc;
                    exp_b = imm_u;
                end
                7'h6f: begin
                    use1  = 1'b0;
                    exp_a = m_pc;
                    exp_b = imm_j;
                end
                default: exp_b = imm_i;    // loads and jalr
            endcase
        end
        stall = (use1 && gpr_busy[held[19:15]]) || (use2 && gpr_busy[held[24:20]]);

        if (!rst) begin
            check_val("ready_if_id", 64'(ready_if_id), 64'(!stall));
            check_val("valid_id_ex", 64'(valid_id_ex), 64'(m_valid && !stall));
            check_val("pc_id_ex", 64'(pc_id_ex), stall ? 64'b0 : 64'(m_pc));
            check_val("inst_id_ex", 64'(inst_id_ex), stall ? 64'b0 : 64'(m_inst));
            check_val("alu_a", 64'(alu_a), 64'(exp_a));
            check_val("alu_b", 64'(alu_b), 64'(exp_b));
            check_val("alu_mode", 64'(alu_mode), 64'(exp_mode));
            check_val("src2", 64'(src2), 64'(s2));
            check_val("rd", 64'(rd), 64'(held[11:7]));
            check_val("wen", 64'(wen), 64'(exp_wen));
            check_val("opcode", 64'(opcode), 64'(op));
        end

        if (!stall) begin
            m_pc   = pc_if_id;
            m_inst = inst_if_id;
        end
        if (rst) m_valid = 1'b0;
        else if (!stall) m_valid = valid_if_id;
    endtask

    // outputs are compared against the state held before the edge
    always @(posedge clk) step_model();

endmodule

// File: tests/tb_clock.sv
// testbench clock and reset
module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;    // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: tests/tb_top.sv
// decode stage testbench
module tb_top import idu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int xlen   = 64;
    localparam int n_idle = 10;
    localparam int n_alu  = 200;
    localparam int n_mem  = 200;
    localparam int n_busy = 300;
    localparam int n_none = 100;
    // two cycles per instruction leaves room for idle beats and stalls
    localparam int total_cycles = n_idle + 2 * (n_alu + n_mem + n_busy + n_none) + 4;

    logic            clk;
    logic            rst;
    logic            valid_if_id;
    logic [xlen-1:0] pc_if_id;
    logic [31:0]     inst_if_id;
    logic [xlen-1:0] gpr [32];
    logic [31:0]     gpr_busy;
    logic            ready_if_id;
    logic            valid_id_ex;
    logic [xlen-1:0] pc_id_ex;
    logic [31:0]     inst_id_ex;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    alu_mode_e       alu_mode;
    logic [xlen-1:0] src2;
    reg_idx_t        rd;
    logic            wen;
    op_e             opcode;
    int              errors;
    int              checks;
    int              seed = 89919;

    tb_clock u_clk (.clk(clk), .rst(rst));

    idu_top #(.xlen(xlen)) u_dut (.*);

    tb_checker #(.xlen(xlen)) u_chk (.*);

    // one instruction from the group with the other fields random
    task automatic make_inst(input int grp, output logic [31:0] inst);
        logic [3:0] k;

        inst = $random(seed);
        k    = 4'($random(seed));
        case (grp)
            0: begin    // register-register
                inst[6:0]   = 7'h33;
                inst[14:12] = k[2:0];
                inst[31:25] = (k[2:0] == 3'd0 && k[3]) ? 7'h20 : 7'h00;
            end
            1: begin    // register-immediate without shifts
                inst[6:0]   = 7'h13;
                inst[14:12] = (k[1:0] == 2'b01) ? {k[2], 2'b10} : k[2:0];
            end
            2: begin    // immediate shifts
                inst[6:0]   = 7'h13;
                inst[14:12] = k[0] ? 3'd5 : 3'd1;
                inst[31:26] = (k[0] && k[1]) ? 6'b010000 : 6'b000000;
            end
            3: begin
                inst[6:0]   = 7'h03;
                inst[14:12] = (k[2:0] == 3'd7) ? 3'd3 : k[2:0];
            end
            4: begin
                inst[6:0]   = 7'h23;
                inst[14:12] = {1'b0, k[1:0]};
            end
            5: begin
                inst[6:0]   = 7'h63;
                inst[14:12] = (k[2:1] == 2'b01) ? {2'b00, k[0]} : k[2:0];
            end
            6: begin
                case (k[1:0])
                    2'd0: inst[6:0] = 7'h37;
                    2'd1: inst[6:0] = 7'h17;
                    2'd2: inst[6:0] = 7'h6f;
                    default: begin
                        inst[6:0]   = 7'h67;
                        inst[14:12] = 3'd0;
                    end
                endcase
            end
            default: ;    // raw random word
        endcase
    endtask

    // upstream holds each instruction until it is accepted
    task automatic run_test(input int grp_lo, input int grp_hi, input int count,
                            input bit use_busy);
        int         accepted;
        bit         pending;
        int         pick;
        int         grp;
        logic [4:0] idx;

        accepted = 0;
        pending  = 1'b0;
        while (accepted < count) begin
            if (!pending) begin
                pick        = $random(seed);
                grp         = grp_lo + (pick & 32'h7fff) % (grp_hi - grp_lo + 1);
                valid_if_id = ($random(seed) & 7) != 0;
                pc_if_id    = {32'($random(seed)), 32'($random(seed))} & ~64'h3;
                make_inst(grp, inst_if_id);
            end
            gpr_busy = use_busy ? ($random(seed) & $random(seed)) : 32'b0;    // about 1 in 4
            idx      = 5'($random(seed));
            gpr[idx] = {32'($random(seed)), 32'($random(seed))};
            @(posedge clk);
            if (valid_if_id && ready_if_id) begin
                accepted++;
                pending = 1'b0;
            end else begin
                pending = valid_if_id;
            end
            @(negedge clk);
        end
        valid_if_id = 1'b0;
        gpr_busy    = 32'b0;
    endtask

    task automatic report_test(input string name, input int base);
        $display("test %s: %0d errors", name, errors - base);
    endtask

    initial begin
        int base;

        valid_if_id = 1'b0;
        pc_if_id    = '0;
        inst_if_id  = 32'b0;
        gpr_busy    = 32'b0;
        for (int i = 0; i < 32; i++)
            gpr[i] = {32'($random(seed)), 32'($random(seed))};
        @(negedge rst);
        @(negedge clk);

        base = errors;
        repeat (n_idle) @(negedge clk);
        report_test("reset and idle", base);

        base = errors;
        run_test(0, 2, n_alu, 1'b0);
        report_test("alu operations", base);

        base = errors;
        run_test(3, 6, n_mem, 1'b0);
        report_test("memory, branch and jump", base);

        base = errors;
        run_test(0, 7, n_busy, 1'b1);
        report_test("busy scoreboard", base);

        base = errors;
        run_test(7, 7, n_none, 1'b1);
        report_test("unknown encodings", base);

        @(negedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(2 * total_cycles * 100);
        $display("timeout: tests did not finish within %0d cycles", 2 * total_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
